// ==== rs_branch.f ====
+incdir+common
common/exec_bus_pkg.sv
common/rs_types_pkg.sv
logic/operand_snoop.sv
rs_branch/rs_entry_array.sv
rs_branch/rs_issue_ctrl.sv
rs_branch/rs_branch.sv
tb/rs_branch_sva.sv
tb/tb_rs_branch.sv

// ==== Bender.yml ====
package:
  name: rs_branch

sources:
  - include_dirs:
      - common
    files:
      - common/exec_bus_pkg.sv
      - common/rs_types_pkg.sv
      - logic/operand_snoop.sv
      - rs_branch/rs_entry_array.sv
      - rs_branch/rs_issue_ctrl.sv
      - rs_branch/rs_branch.sv

  - target: test
    include_dirs:
      - common
    files:
      - tb/rs_branch_sva.sv
      - tb/tb_rs_branch.sv

export_include_dirs:
  - common

// ==== tb/tb_rs_branch.sv ====
`timescale 1ns/1ns
`include "rs_defines.svh"

module tb_rs_branch;
    import rs_types_pkg::*;
    import exec_bus_pkg::*;

    localparam int NUM_DISP   = 400;
    localparam int MAX_CYCLES = NUM_DISP * 12;

    // one broadcast still owed to a waiting operand
    typedef struct packed {
        logic [`TAG_W-1:0] tag;
        int                idx;
        int                op;
        int                due;
    } pend_t;

    logic         clk;
    logic         reset;
    logic         dispatch_valid;
    br_dispatch_t dispatch;
    result_bus_t  buses [`NUM_RESULT_BUSES];
    logic         issue_valid;
    br_issue_t    issue;

    logic [31:0]       lcg_state;
    logic [`TAG_W-1:0] next_tag;
    int                errors = 0;
    int                cycle = 0;
    int                disp_count;
    int                exp_rd;        // issues seen so far
    br_issue_t         exp_mem [NUM_DISP];
    int                waits_left [NUM_DISP];
    pend_t             pend_q [$];

    rs_branch rs_branch_i (
        .clk            (clk),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .buses          (buses),
        .issue_valid    (issue_valid),
        .issue          (issue)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    function automatic logic [31:0] rand_word();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = rand_word();
        return int'(r >> 8) % n;   // low bits of an lcg are weak
    endfunction

    task automatic log_failure(input string msg);
        errors++;
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
    endtask

    task automatic clear_buses();
        for (int i = 0; i < `NUM_RESULT_BUSES; i++) begin
            buses[i] = '0;
        end
    endtask

    function automatic int free_bus(input int start);
        int i;
        for (int k = 0; k < `NUM_RESULT_BUSES; k++) begin
            i = (start + k) % `NUM_RESULT_BUSES;
            if (!buses[i].valid) return i;
        end
        return -1;
    endfunction

    function automatic operand_t make_operand(input int idx, input int opn,
                                              input int step, input logic force_ready);
        operand_t o;
        pend_t    p;
        int       delay;
        o.tag   = `TAG_W'(rand_word());
        o.data  = rand_word();
        o.ready = 1'b1;
        if (!force_ready && rand_below(2) == 0) begin
            delay   = (rand_below(4) == 0) ? 0 : 1 + rand_below(12);
            o.ready = 1'b0;
            o.tag   = next_tag;   // unique while in flight
            next_tag = next_tag + 1'b1;
            p.tag = o.tag;
            p.idx = idx;
            p.op  = opn;
            p.due = step + delay;
            pend_q.push_back(p);
            waits_left[idx]++;
        end
        return o;
    endfunction

    task automatic dispatch_one(input int step);
        br_dispatch_t d;
        br_issue_t    e;
        int           idx;
        logic         force_ready;
        idx = disp_count;
        force_ready = (idx % 40 == 0);
        waits_left[idx] = 0;
        d.inst_num   = 32'(idx);
        d.pc         = rand_word() & ~32'h3;
        d.rd         = `TAG_W'(rand_word());
        d.jump       = (rand_below(3) == 0);
        d.branch     = !d.jump;
        d.funct3     = 3'(rand_below(8));
        d.imm        = rand_word();
        d.pred_taken = (rand_below(2) == 1);
        d.btb_hit    = (rand_below(2) == 1);
        d.op1        = make_operand(idx, 1, step, force_ready);
        d.op2        = make_operand(idx, 2, step, force_ready);
        e.inst_num   = d.inst_num;
        e.pc         = d.pc;
        e.rd         = d.rd;
        e.jump       = d.jump;
        e.branch     = d.branch;
        e.funct3     = d.funct3;
        e.imm        = d.imm;
        e.pred_taken = d.pred_taken;
        e.btb_hit    = d.btb_hit;
        e.op1_data   = d.op1.data;   // waiting operands get filled on broadcast
        e.op2_data   = d.op2.data;
        exp_mem[idx] = e;
        dispatch       = d;
        dispatch_valid = 1'b1;
        disp_count++;
    endtask

    task automatic fill_expected(input pend_t p, input logic [`XLEN-1:0] win);
        if (p.op == 1) begin
            exp_mem[p.idx].op1_data = win;
        end else begin
            exp_mem[p.idx].op2_data = win;
        end
        waits_left[p.idx]--;
    endtask

    task automatic send_broadcasts(input int step);
        pend_t            keep [$];
        pend_t            p;
        int               b;
        int               b2;
        logic [`XLEN-1:0] win;
        while (pend_q.size() != 0) begin
            p = pend_q.pop_front();
            b = (p.due <= step) ? free_bus(rand_below(`NUM_RESULT_BUSES)) : -1;
            if (b < 0) begin
                keep.push_back(p);   // not due yet, or every bus taken
            end else begin
                buses[b] = '{valid: 1'b1, tag: p.tag, data: rand_word()};
                win = buses[b].data;
                if (rand_below(5) == 0) begin
                    b2 = free_bus(rand_below(`NUM_RESULT_BUSES));
                    if (b2 >= 0) begin
                        buses[b2] = '{valid: 1'b1, tag: p.tag, data: ~win};
                        if (b2 < b) win = ~win;   // lower bus index wins
                    end
                end
                fill_expected(p, win);
            end
        end
        pend_q = keep;
    endtask

    always @(posedge clk) begin
        if (reset) begin
            exp_rd <= 0;
        end else if (issue_valid) begin
            exp_rd <= exp_rd + 1;
        end
    end

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (cycle >= MAX_CYCLES) begin
            $display("timeout: run stopped after %0d cycles with %0d of %0d issues seen",
                     cycle, exp_rd, NUM_DISP);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    quiet_before_dispatch: assert property (@(posedge clk) disable iff (reset)
        disp_count == 0 |-> !issue_valid)
        else log_failure("issue_valid high before any dispatch");

    // queue drained before this dispatch, so it goes straight out
    ready_latency: assert property (@(posedge clk) disable iff (reset)
        dispatch_valid && dispatch.op1.ready && dispatch.op2.ready &&
        (disp_count - 1 == exp_rd + int'(issue_valid))
        |-> ##2 (issue_valid && issue.inst_num == $past(dispatch.inst_num, 2)))
        else log_failure("ready dispatch at empty queue not issued on time");

    issue_in_order: assert property (@(posedge clk) disable iff (reset)
        issue_valid |-> exp_rd < NUM_DISP && issue == exp_mem[exp_rd])
        else log_failure("issued payload differs from the expected queue head");

    issue_after_wakeup: assert property (@(posedge clk) disable iff (reset)
        issue_valid |-> exp_rd < NUM_DISP && waits_left[exp_rd] == 0)
        else log_failure("entry issued before its tags were broadcast");

    initial begin
        int step;
        int in_flight;
        lcg_state      = 32'h25714780;
        next_tag       = '0;
        disp_count     = 0;
        step           = 0;
        reset          = 1'b1;
        dispatch_valid = 1'b0;
        dispatch       = '0;
        clear_buses();
        repeat (8) @(posedge clk);
        #1 reset = 1'b0;
        repeat (3) @(posedge clk);
        while (disp_count < NUM_DISP || pend_q.size() != 0) begin
            @(posedge clk);
            #1;
            step++;
            dispatch_valid = 1'b0;
            clear_buses();
            in_flight = disp_count - exp_rd;
            // drain every 20 dispatches so some land at an empty queue
            if (disp_count < NUM_DISP && in_flight < `RS_DEPTH - 1 &&
                !(disp_count % 20 == 0 && in_flight != 0) && rand_below(4) != 0) begin
                dispatch_one(step);
            end
            send_broadcasts(step);
        end
        @(posedge clk);
        #1;
        dispatch_valid = 1'b0;
        clear_buses();
        while (exp_rd < disp_count) begin
            @(posedge clk);
        end
        repeat (3) @(posedge clk);
        errors += rs_branch_i.rs_branch_sva_i.fail_count;
        $display("checks finished: %0d errors over %0d dispatches and %0d issues",
                 errors, disp_count, exp_rd);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== tb/rs_branch_sva.sv ====
`timescale 1ns/1ns
`include "rs_defines.svh"

module rs_branch_sva (
    input logic clk,
    input logic reset,
    input logic dispatch_valid,
    input logic issue_fire,
    input logic issue_valid
);
    localparam int CNT_W = $clog2(`RS_DEPTH) + 1;

    logic [CNT_W-1:0] occupancy;   // shadow count of queued entries
    int               fail_count = 0;

    always_ff @(posedge clk) begin
        if (reset) begin
            occupancy <= '0;
        end else begin
            occupancy <= occupancy + CNT_W'(dispatch_valid) - CNT_W'(issue_fire);
        end
    end

    no_dispatch_when_full: assert property (@(posedge clk) disable iff (reset)
        dispatch_valid |-> occupancy < CNT_W'(`RS_DEPTH))
        else begin
            fail_count++;
            $error("dispatch into a full branch queue");
        end

    no_issue_when_empty: assert property (@(posedge clk) disable iff (reset)
        issue_fire |-> occupancy != '0)
        else begin
            fail_count++;
            $error("issue from an empty branch queue");
        end

    quiet_after_reset: assert property (@(posedge clk)
        $fell(reset) |-> !issue_valid)
        else begin
            fail_count++;
            $error("issue_valid high in the first cycle after reset");
        end

endmodule

bind rs_branch rs_branch_sva rs_branch_sva_i (
    .clk            (clk),
    .reset          (reset),
    .dispatch_valid (dispatch_valid),
    .issue_fire     (issue_fire),
    .issue_valid    (issue_valid)
);

// ==== rs_branch/rs_branch.sv ====
`timescale 1ns/1ns
`include "rs_defines.svh"

module rs_branch (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       dispatch_valid,
    input  rs_types_pkg::br_dispatch_t dispatch,
    input  exec_bus_pkg::result_bus_t  buses [`NUM_RESULT_BUSES],
    output logic                       issue_valid,
    output rs_types_pkg::br_issue_t    issue
);
    import rs_types_pkg::*;

    localparam int IDX_W = $clog2(`RS_DEPTH);

    logic [IDX_W-1:0]     tail_ptr;
    logic [IDX_W-1:0]     head_ptr;
    logic [`RS_DEPTH-1:0] entry_ready;
    logic                 issue_fire;
    br_issue_t            head_payload;

    rs_entry_array entry_array_i (
        .clk            (clk),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .tail_ptr       (tail_ptr),
        .head_ptr       (head_ptr),
        .issue_fire     (issue_fire),
        .buses          (buses),
        .entry_ready    (entry_ready),
        .head_payload   (head_payload)
    );

    rs_issue_ctrl issue_ctrl_i (
        .clk            (clk),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .entry_ready    (entry_ready),
        .head_payload   (head_payload),
        .tail_ptr       (tail_ptr),
        .head_ptr       (head_ptr),
        .issue_fire     (issue_fire),
        .issue_valid    (issue_valid),
        .issue          (issue)
    );

endmodule

// ==== rs_branch/rs_issue_ctrl.sv ====
`timescale 1ns/1ns
`include "rs_defines.svh"

module rs_issue_ctrl (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         dispatch_valid,
    input  logic [`RS_DEPTH-1:0]         entry_ready,
    input  rs_types_pkg::br_issue_t      head_payload,
    output logic [$clog2(`RS_DEPTH)-1:0] tail_ptr,
    output logic [$clog2(`RS_DEPTH)-1:0] head_ptr,
    output logic                         issue_fire,
    output logic                         issue_valid,
    output rs_types_pkg::br_issue_t      issue
);
    import rs_types_pkg::*;

    localparam int IDX_W = $clog2(`RS_DEPTH);

    // top bit is the wrap flag
    logic [IDX_W:0] head_q;
    logic [IDX_W:0] tail_q;
    logic           empty;

    assign tail_ptr = tail_q[IDX_W-1:0];
    assign head_ptr = head_q[IDX_W-1:0];
    assign empty    = (head_q == tail_q);

    // strictly in order, only the head may go
    assign issue_fire = !empty && entry_ready[head_ptr];

    always_ff @(posedge clk) begin
        if (reset) begin
            head_q      <= '0;
            tail_q      <= '0;
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= issue_fire;
            if (dispatch_valid) tail_q <= tail_q + 1'b1;
            if (issue_fire) head_q <= head_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_fire) issue <= head_payload;   // held until next issue
    end

    // wrap bit scheme only works when the pointers span the whole queue
    initial begin
        if ((1 << IDX_W) != `RS_DEPTH) begin
            $error("rs_issue_ctrl: RS_DEPTH must be a power of two");
        end
    end

endmodule

// ==== rs_branch/rs_entry_array.sv ====
`timescale 1ns/1ns
`include "rs_defines.svh"

module rs_entry_array (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            dispatch_valid,
    input  rs_types_pkg::br_dispatch_t      dispatch,
    input  logic [$clog2(`RS_DEPTH)-1:0]    tail_ptr,
    input  logic [$clog2(`RS_DEPTH)-1:0]    head_ptr,
    input  logic                            issue_fire,
    input  exec_bus_pkg::result_bus_t       buses [`NUM_RESULT_BUSES],
    output logic [`RS_DEPTH-1:0]            entry_ready,
    output rs_types_pkg::br_issue_t         head_payload
);
    import rs_types_pkg::*;

    br_dispatch_t         slot [`RS_DEPTH];   // payload, ready bits live below
    logic [`RS_DEPTH-1:0] busy;
    logic [`RS_DEPTH-1:0] rdy1;
    logic [`RS_DEPTH-1:0] rdy2;

    logic                 disp_hit1;
    logic                 disp_hit2;
    logic [`XLEN-1:0]     disp_data1;
    logic [`XLEN-1:0]     disp_data2;
    br_dispatch_t         disp_entry;

    logic [`RS_DEPTH-1:0] wake1;
    logic [`RS_DEPTH-1:0] wake2;
    logic [`XLEN-1:0]     wake1_data [`RS_DEPTH];
    logic [`XLEN-1:0]     wake2_data [`RS_DEPTH];

    // capture in the dispatch cycle
    operand_snoop disp_snoop1_i (
        .tag   (dispatch.op1.tag),
        .buses (buses),
        .hit   (disp_hit1),
        .data  (disp_data1)
    );

    operand_snoop disp_snoop2_i (
        .tag   (dispatch.op2.tag),
        .buses (buses),
        .hit   (disp_hit2),
        .data  (disp_data2)
    );

    for (genvar g = 0; g < `RS_DEPTH; g++) begin : g_wake
        operand_snoop snoop1_i (
            .tag   (slot[g].op1.tag),
            .buses (buses),
            .hit   (wake1[g]),
            .data  (wake1_data[g])
        );

        operand_snoop snoop2_i (
            .tag   (slot[g].op2.tag),
            .buses (buses),
            .hit   (wake2[g]),
            .data  (wake2_data[g])
        );
    end

    always_comb begin
        disp_entry = dispatch;
        if (!dispatch.op1.ready && disp_hit1) disp_entry.op1.data = disp_data1;
        if (!dispatch.op2.ready && disp_hit2) disp_entry.op2.data = disp_data2;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= '0;
            rdy1 <= '0;
            rdy2 <= '0;
        end else begin
            for (int e = 0; e < `RS_DEPTH; e++) begin
                if (busy[e] && !rdy1[e] && wake1[e]) rdy1[e] <= 1'b1;
                if (busy[e] && !rdy2[e] && wake2[e]) rdy2[e] <= 1'b1;
            end
            if (issue_fire) begin
                busy[head_ptr] <= 1'b0;
                rdy1[head_ptr] <= 1'b0;
                rdy2[head_ptr] <= 1'b0;
            end
            // tail never equals an issuing head, queue is not full
            if (dispatch_valid) begin
                busy[tail_ptr] <= 1'b1;
                rdy1[tail_ptr] <= dispatch.op1.ready | disp_hit1;
                rdy2[tail_ptr] <= dispatch.op2.ready | disp_hit2;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int e = 0; e < `RS_DEPTH; e++) begin
            if (busy[e] && !rdy1[e] && wake1[e]) slot[e].op1.data <= wake1_data[e];
            if (busy[e] && !rdy2[e] && wake2[e]) slot[e].op2.data <= wake2_data[e];
        end
        if (dispatch_valid) slot[tail_ptr] <= disp_entry;
    end

    assign entry_ready = busy & rdy1 & rdy2;

    always_comb begin
        head_payload.inst_num   = slot[head_ptr].inst_num;
        head_payload.pc         = slot[head_ptr].pc;
        head_payload.rd         = slot[head_ptr].rd;
        head_payload.jump       = slot[head_ptr].jump;
        head_payload.branch     = slot[head_ptr].branch;
        head_payload.funct3     = slot[head_ptr].funct3;
        head_payload.imm        = slot[head_ptr].imm;
        head_payload.pred_taken = slot[head_ptr].pred_taken;
        head_payload.btb_hit    = slot[head_ptr].btb_hit;
        head_payload.op1_data   = slot[head_ptr].op1.data;
        head_payload.op2_data   = slot[head_ptr].op2.data;
    end

endmodule

// ==== logic/operand_snoop.sv ====
`timescale 1ns/1ns
`include "rs_defines.svh"

module operand_snoop (
    input  logic [`TAG_W-1:0]        tag,
    input  exec_bus_pkg::result_bus_t buses [`NUM_RESULT_BUSES],
    output logic                     hit,
    output logic [`XLEN-1:0]         data
);
    import exec_bus_pkg::*;

    // walk from lowest priority up so the lowest index is the last write
    always_comb begin
        hit  = 1'b0;
        data = '0;
        for (int i = int'(BUS_BR_RET); i >= int'(BUS_ALU); i--) begin
            if (buses[i].valid && buses[i].tag == tag) begin
                hit  = 1'b1;
                data = buses[i].data;
            end
        end
    end

    // every bus must have a place in the priority order
    initial begin
        if (`NUM_RESULT_BUSES != int'(BUS_BR_RET) + 1) begin
            $error("operand_snoop: bus count does not match bus_src_e");
        end
    end

endmodule

// ==== common/rs_types_pkg.sv ====
`include "rs_defines.svh"

package rs_types_pkg;

    typedef struct packed {
        logic [`TAG_W-1:0] tag;
        logic [`XLEN-1:0]  data;
        logic              ready;
    } operand_t;

    // one branch or jump as it leaves rename
    typedef struct packed {
        logic [31:0]       inst_num;
        logic [`XLEN-1:0]  pc;
        logic [`TAG_W-1:0] rd;
        logic              jump;
        logic              branch;
        logic [2:0]        funct3;
        logic [31:0]       imm;
        logic              pred_taken;
        logic              btb_hit;
        operand_t          op1;
        operand_t          op2;
    } br_dispatch_t;

    // what the branch unit needs, tags and flags dropped
    typedef struct packed {
        logic [31:0]       inst_num;
        logic [`XLEN-1:0]  pc;
        logic [`TAG_W-1:0] rd;
        logic              jump;
        logic              branch;
        logic [2:0]        funct3;
        logic [31:0]       imm;
        logic              pred_taken;
        logic              btb_hit;
        logic [`XLEN-1:0]  op1_data;
        logic [`XLEN-1:0]  op2_data;
    } br_issue_t;

endpackage

// ==== common/exec_bus_pkg.sv ====
`include "rs_defines.svh"

package exec_bus_pkg;

    // one broadcast from an execution unit
    typedef struct packed {
        logic              valid;
        logic [`TAG_W-1:0] tag;    // destination
        logic [`XLEN-1:0]  data;
    } result_bus_t;

    // index into the bus array, lower index wins on a tag clash
    typedef enum logic [2:0] {
        BUS_ALU    = 3'd0,
        BUS_MUL    = 3'd1,
        BUS_DIV    = 3'd2,
        BUS_LOAD   = 3'd3,
        BUS_BR_RET = 3'd4
    } bus_src_e;

endpackage

// ==== common/rs_defines.svh ====
`ifndef RS_DEFINES_SVH
`define RS_DEFINES_SVH

// queue entries, keep a power of two
`define RS_DEPTH 16

// physical register tag
`define TAG_W 8

// data and pc width
`define XLEN 32

// alu, mul, div, load, branch return
`define NUM_RESULT_BUSES 5

`endif
